/* shade_pkg.sv */
`default_nettype none

package shade_pkg;

    // signed vertex coordinate and the difference of two of them
    localparam int COORD_W = 12;
    localparam int EDGE_W = 13;

    // cross product component, also the multiplier operand width
    localparam int NORM_W = 27;
    localparam int PROD_W = 54;

    // room for the sum of three squared components
    localparam int MAG_W = 56;

    // grant to response in the shared multiplier
    localparam int MULT_LAT = 3;

    // light at (0, 0, -1), so the dot product with the normal is -nz.
    // only its square enters the cosine, and a negative nz marks a back face.
    // cos^2 is scaled by 16 before it becomes a table index
    localparam int COS_SCALE_LOG2 = 4;
    localparam int INDEX_W = 4;

    typedef logic signed [COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    // vertex 0 sits at index 0
    typedef vertex_t [2:0] triangle_t;

    typedef logic signed [NORM_W-1:0] norm_t;
    typedef logic signed [PROD_W-1:0] prod_t;
    typedef logic [MAG_W-1:0] mag_t;
    typedef logic [7:0] color_t;

    // tag carried beside each product in the multiplier pipeline
    typedef enum logic {
        REQ_NORM = 1'b0,
        REQ_MAG  = 1'b1
    } req_id_t;

    localparam color_t COLOR_BACK = 8'd255;

    // grey level by floor(16 * cos^2), brightest entry saturates at 255
    localparam color_t COLOR_TABLE [2**INDEX_W] = '{
        8'd0,   8'd20,  8'd40,  8'd60,  8'd78,  8'd96,  8'd114, 8'd130,
        8'd146, 8'd162, 8'd178, 8'd194, 8'd210, 8'd226, 8'd242, 8'd255
    };

endpackage

`default_nettype wire

/* shade_ifs.sv */
`default_nettype none

// one instance per requester of the shared multiplier
interface mult_if;
    import shade_pkg::*;

    // req is held until grant, grant marks the cycle the operands are taken
    logic  req;
    norm_t a;
    norm_t b;
    logic  grant;
    // pulses MULT_LAT cycles after the matching grant
    logic  rsp_valid;
    prod_t product;

    modport requester (
        output req, a, b,
        input  grant, rsp_valid, product
    );

    modport arbiter (
        input  req, a, b,
        output grant, rsp_valid, product
    );
endinterface

// normal vector from normal_unit to magnitude_unit
interface normal_if;
    import shade_pkg::*;

    // valid holds with the data until a cycle with busy low
    logic  valid;
    norm_t nx;
    norm_t ny;
    norm_t nz;
    logic  busy;

    modport source (output valid, nx, ny, nz, input busy);
    modport sink   (input valid, nx, ny, nz, output busy);
endinterface

// z component and squared magnitude from magnitude_unit to shade_color
interface ratio_if;
    import shade_pkg::*;

    // same hand-over rule as normal_if
    logic  valid;
    norm_t nz;
    mag_t  mag;
    logic  busy;

    modport source (output valid, nz, mag, input busy);
    modport sink   (input valid, nz, mag, output busy);
endinterface

`default_nettype wire

/* mult_arbiter.sv */
`default_nettype none

module mult_arbiter (
    input  logic     clk,
    input  logic     rst_in,
    mult_if.arbiter  norm_port,
    mult_if.arbiter  mag_port
);
    import shade_pkg::*;

    logic                take_mag;
    logic                take_norm;
    req_id_t             take_id;
    norm_t               a_q;
    norm_t               b_q;
    logic [MULT_LAT-1:0] vld_pipe;
    req_id_t             id_pipe [MULT_LAT];
    prod_t               prod_pipe [MULT_LAT-1];

    // the magnitude unit wins since it frees up the normal unit
    assign take_mag  = mag_port.req;
    assign take_norm = norm_port.req && !mag_port.req;
    assign take_id   = take_mag ? REQ_MAG : REQ_NORM;

    assign mag_port.grant  = take_mag;
    assign norm_port.grant = take_norm;

    always_ff @(posedge clk) begin
        if (rst_in) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[MULT_LAT-2:0], take_mag | take_norm};
        end
    end

    // stage 1 holds the operands and the later stages carry the product
    always_ff @(posedge clk) begin
        a_q <= take_mag ? mag_port.a : norm_port.a;
        b_q <= take_mag ? mag_port.b : norm_port.b;
        id_pipe[0] <= take_id;
        for (int i = 1; i < MULT_LAT; i++) begin
            id_pipe[i] <= id_pipe[i-1];
        end
        prod_pipe[0] <= prod_t'(a_q) * prod_t'(b_q);
        for (int i = 1; i < MULT_LAT - 1; i++) begin
            prod_pipe[i] <= prod_pipe[i-1];
        end
    end

    // both ports see the product and the tag picks who gets the pulse
    assign norm_port.product = prod_pipe[MULT_LAT-2];
    assign mag_port.product  = prod_pipe[MULT_LAT-2];

    assign norm_port.rsp_valid = vld_pipe[MULT_LAT-1]
                                 && (id_pipe[MULT_LAT-1] == REQ_NORM);
    assign mag_port.rsp_valid  = vld_pipe[MULT_LAT-1]
                                 && (id_pipe[MULT_LAT-1] == REQ_MAG);

endmodule

`default_nettype wire

/* normal_unit.sv */
`default_nettype none

module normal_unit (
    input  logic                 clk,
    input  logic                 rst_in,
    input  logic                 data_valid_in,
    input  shade_pkg::triangle_t triangle,
    output logic                 ready,
    mult_if.requester            mul,
    normal_if.source             out_port
);
    import shade_pkg::*;

    logic signed [EDGE_W-1:0] u_edge [3];
    logic signed [EDGE_W-1:0] w_edge [3];
    logic signed [EDGE_W-1:0] u_r [3];
    logic signed [EDGE_W-1:0] w_r [3];
    norm_t                    n_r [3];
    norm_t                    prod_lo;
    logic [1:0]               n_idx;
    logic                     busy_r;
    logic                     done_r;
    logic [2:0]               issue_cnt;
    logic [2:0]               ret_cnt;
    logic                     accept;

    // u = v1 - v0 and w = v2 - v0
    assign u_edge[0] = EDGE_W'(triangle[1].x) - EDGE_W'(triangle[0].x);
    assign u_edge[1] = EDGE_W'(triangle[1].y) - EDGE_W'(triangle[0].y);
    assign u_edge[2] = EDGE_W'(triangle[1].z) - EDGE_W'(triangle[0].z);
    assign w_edge[0] = EDGE_W'(triangle[2].x) - EDGE_W'(triangle[0].x);
    assign w_edge[1] = EDGE_W'(triangle[2].y) - EDGE_W'(triangle[0].y);
    assign w_edge[2] = EDGE_W'(triangle[2].z) - EDGE_W'(triangle[0].z);

    assign ready  = !busy_r;
    assign accept = data_valid_in && !busy_r;

    // six products in pairs that make nx, ny and nz
    assign mul.req = busy_r && (issue_cnt != 3'd6);

    always_comb begin
        case (issue_cnt)
            3'd0: begin
                mul.a = norm_t'(u_r[1]);
                mul.b = norm_t'(w_r[2]);
            end
            3'd1: begin
                mul.a = norm_t'(u_r[2]);
                mul.b = norm_t'(w_r[1]);
            end
            3'd2: begin
                mul.a = norm_t'(u_r[2]);
                mul.b = norm_t'(w_r[0]);
            end
            3'd3: begin
                mul.a = norm_t'(u_r[0]);
                mul.b = norm_t'(w_r[2]);
            end
            3'd4: begin
                mul.a = norm_t'(u_r[0]);
                mul.b = norm_t'(w_r[1]);
            end
            default: begin
                mul.a = norm_t'(u_r[1]);
                mul.b = norm_t'(w_r[0]);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_in) begin
            busy_r    <= 1'b0;
            done_r    <= 1'b0;
            issue_cnt <= '0;
            ret_cnt   <= '0;
        end else begin
            if (accept) begin
                busy_r    <= 1'b1;
                issue_cnt <= '0;
                ret_cnt   <= '0;
            end
            if (mul.grant) begin
                issue_cnt <= issue_cnt + 3'd1;
            end
            if (mul.rsp_valid) begin
                ret_cnt <= ret_cnt + 3'd1;
                if (ret_cnt == 3'd5) begin
                    done_r <= 1'b1;
                end
            end
            // hand-over to the magnitude unit frees us for the next triangle
            if (done_r && !out_port.busy) begin
                busy_r <= 1'b0;
                done_r <= 1'b0;
            end
        end
    end

    // products fit in NORM_W bits
    assign prod_lo = mul.product[NORM_W-1:0];
    assign n_idx   = ret_cnt[2:1];

    always_ff @(posedge clk) begin
        if (accept) begin
            u_r <= u_edge;
            w_r <= w_edge;
        end
        // even returns start a component and odd ones subtract
        if (mul.rsp_valid) begin
            if (!ret_cnt[0]) begin
                n_r[n_idx] <= prod_lo;
            end else begin
                n_r[n_idx] <= n_r[n_idx] - prod_lo;
            end
        end
    end

    assign out_port.valid = done_r;
    assign out_port.nx    = n_r[0];
    assign out_port.ny    = n_r[1];
    assign out_port.nz    = n_r[2];

endmodule

`default_nettype wire

/* magnitude_unit.sv */
`default_nettype none

module magnitude_unit (
    input  logic      clk,
    input  logic      rst_in,
    normal_if.sink    in_port,
    mult_if.requester mul,
    ratio_if.source   out_port
);
    import shade_pkg::*;

    norm_t      n_r [3];
    norm_t      sq_op;
    mag_t       mag_acc;
    logic       busy_r;
    logic       done_r;
    logic [1:0] issue_cnt;
    logic [1:0] ret_cnt;
    logic       accept;

    assign accept       = in_port.valid && !busy_r;
    assign in_port.busy = busy_r;

    // nx^2, ny^2, nz^2 back to back
    assign mul.req = busy_r && (issue_cnt != 2'd3);

    always_comb begin
        case (issue_cnt)
            2'd0:    sq_op = n_r[0];
            2'd1:    sq_op = n_r[1];
            default: sq_op = n_r[2];
        endcase
    end

    assign mul.a = sq_op;
    assign mul.b = sq_op;

    always_ff @(posedge clk) begin
        if (rst_in) begin
            busy_r    <= 1'b0;
            done_r    <= 1'b0;
            issue_cnt <= '0;
            ret_cnt   <= '0;
        end else begin
            if (accept) begin
                busy_r    <= 1'b1;
                issue_cnt <= '0;
                ret_cnt   <= '0;
            end
            if (mul.grant) begin
                issue_cnt <= issue_cnt + 2'd1;
            end
            if (mul.rsp_valid) begin
                ret_cnt <= ret_cnt + 2'd1;
                if (ret_cnt == 2'd2) begin
                    done_r <= 1'b1;
                end
            end
            if (done_r && !out_port.busy) begin
                busy_r <= 1'b0;
                done_r <= 1'b0;
            end
        end
    end

    // squares are never negative, so widen without sign
    always_ff @(posedge clk) begin
        if (accept) begin
            n_r[0]  <= in_port.nx;
            n_r[1]  <= in_port.ny;
            n_r[2]  <= in_port.nz;
            mag_acc <= '0;
        end else if (mul.rsp_valid) begin
            mag_acc <= mag_acc + MAG_W'($unsigned(mul.product));
        end
    end

    // nz rides along for the cosine and the facing test
    assign out_port.valid = done_r;
    assign out_port.nz    = n_r[2];
    assign out_port.mag   = mag_acc;

endmodule

`default_nettype wire

/* shade_color.sv */
`default_nettype none

module shade_color (
    input  logic              clk,
    input  logic              rst_in,
    ratio_if.sink             in_port,
    output logic              valid_out,
    output shade_pkg::color_t color_out
);
    import shade_pkg::*;

    norm_t                      nz_r;
    mag_t                       mag_r;
    logic                       busy_r;
    logic [2:0]                 step;
    logic [2:0]                 bit_idx;
    logic [INDEX_W:0]           quo;
    logic [NORM_W-1:0]          nz_abs;
    logic [PROD_W-1:0]          nz_sq;
    logic [MAG_W+INDEX_W:0]     rem;
    logic [MAG_W+INDEX_W:0]     rem_cur;
    logic [MAG_W+INDEX_W:0]     div_shift;
    logic                       fits;
    logic                       dividing;
    logic                       last;
    logic [INDEX_W-1:0]         index;
    color_t                     color_next;

    // unsigned square by shift and add
    function automatic logic [PROD_W-1:0] square_u(input logic [NORM_W-1:0] v);
        logic [PROD_W-1:0] acc;
        acc = '0;
        for (int i = 0; i < NORM_W; i++) begin
            if (v[i]) begin
                acc = acc + (PROD_W'(v) << i);
            end
        end
        return acc;
    endfunction

    assign in_port.busy = busy_r;

    // steps 0..INDEX_W divide, the step after that emits the colour
    assign dividing = busy_r && (step <= 3'(INDEX_W));
    assign last     = busy_r && (step == 3'(INDEX_W + 1));
    assign bit_idx  = 3'(INDEX_W) - step;

    // numerator 16 * nz^2 only enters in the first step
    assign nz_abs    = nz_r[NORM_W-1] ? -nz_r : nz_r;
    assign nz_sq     = square_u(nz_abs);
    assign rem_cur   = (step == 3'd0) ? ((MAG_W + INDEX_W + 1)'(nz_sq) << COS_SCALE_LOG2)
                                      : rem;
    assign div_shift = (MAG_W + INDEX_W + 1)'(mag_r) << bit_idx;
    assign fits      = rem_cur >= div_shift;

    // cos^2 cannot exceed 1, but 16/16 lands one past the table
    assign index = quo[INDEX_W] ? '1 : quo[INDEX_W-1:0];

    always_comb begin
        if (nz_r[NORM_W-1]) begin
            color_next = COLOR_BACK;
        end else if (mag_r == '0) begin
            // zero normal, nothing to light
            color_next = '0;
        end else begin
            color_next = COLOR_TABLE[index];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_in) begin
            busy_r    <= 1'b0;
            step      <= '0;
            valid_out <= 1'b0;
        end else begin
            valid_out <= 1'b0;
            if (in_port.valid && !busy_r) begin
                busy_r <= 1'b1;
                step   <= '0;
            end
            if (dividing) begin
                step <= step + 3'd1;
            end
            if (last) begin
                busy_r    <= 1'b0;
                valid_out <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_port.valid && !busy_r) begin
            nz_r  <= in_port.nz;
            mag_r <= in_port.mag;
        end
        // one restoring step per quotient bit, msb first
        if (dividing) begin
            rem          <= fits ? rem_cur - div_shift : rem_cur;
            quo[bit_idx] <= fits;
        end
        if (last) begin
            color_out <= color_next;
        end
    end

endmodule

`default_nettype wire

/* pixel_shader.sv */
`default_nettype none

module pixel_shader (
    input  logic                 clk,
    input  logic                 rst_in,
    input  logic                 data_valid_in,
    input  shade_pkg::triangle_t triangle,
    output logic                 ready,
    output logic                 valid_out,
    output shade_pkg::color_t    color_out
);

    // one multiplier link per requester
    mult_if   norm_mul ();
    mult_if   mag_mul ();
    normal_if normal_link ();
    ratio_if  ratio_link ();

    mult_arbiter mult_arbiter_inst (
        .clk       (clk),
        .rst_in    (rst_in),
        .norm_port (norm_mul.arbiter),
        .mag_port  (mag_mul.arbiter)
    );

    // edges and cross product
    normal_unit normal_unit_inst (
        .clk           (clk),
        .rst_in        (rst_in),
        .data_valid_in (data_valid_in),
        .triangle      (triangle),
        .ready         (ready),
        .mul           (norm_mul.requester),
        .out_port      (normal_link.source)
    );

    // squared length of the normal
    magnitude_unit magnitude_unit_inst (
        .clk      (clk),
        .rst_in   (rst_in),
        .in_port  (normal_link.sink),
        .mul      (mag_mul.requester),
        .out_port (ratio_link.source)
    );

    // cos^2 by division, then grey level
    shade_color shade_color_inst (
        .clk       (clk),
        .rst_in    (rst_in),
        .in_port   (ratio_link.sink),
        .valid_out (valid_out),
        .color_out (color_out)
    );

endmodule

`default_nettype wire

/* tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_in
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk    = 1'b0;
        rst_in = 1'b1;
        repeat (10) @(posedge clk);
        rst_in <= 1'b0;
    end

    // 10 ns period
    always #5 clk = ~clk;

endmodule

`default_nettype wire

/* tb_pixel_shader.sv */
`default_nettype none

module tb_pixel_shader;
    timeunit 1ns;
    timeprecision 1ps;

    import shade_pkg::*;

    localparam int RANDOM_COUNT = 40;
    // 2 front, 2 back, 2 zero normal, then the random stream
    localparam int NUM_TRIANGLES = 6 + RANDOM_COUNT;
    localparam int CYCLES_PER_TRIANGLE = 400;
    localparam int TIMEOUT_CYCLES = NUM_TRIANGLES * CYCLES_PER_TRIANGLE;
    localparam logic [31:0] LFSR_SEED = 32'hfd8e_5339;

    // grey levels by floor(16 * cos^2)
    localparam color_t SHADE_LEVELS [16] = '{
        8'd0,   8'd20,  8'd40,  8'd60,  8'd78,  8'd96,  8'd114, 8'd130,
        8'd146, 8'd162, 8'd178, 8'd194, 8'd210, 8'd226, 8'd242, 8'd255
    };

    logic        clk;
    logic        rst_in;
    logic        data_valid_in;
    triangle_t   triangle;
    logic        ready;
    logic        valid_out;
    color_t      color_out;

    int          error_count;
    int          cycle_cnt;
    string       test_name;
    logic [31:0] lfsr_state;
    color_t      expected_q [$];
    color_t      exp_color;

    tb_clock tb_clock_inst (
        .clk    (clk),
        .rst_in (rst_in)
    );

    pixel_shader pixel_shader_inst (
        .clk           (clk),
        .rst_in        (rst_in),
        .data_valid_in (data_valid_in),
        .triangle      (triangle),
        .ready         (ready),
        .valid_out     (valid_out),
        .color_out     (color_out)
    );

    task automatic check_color(input string name, input color_t exp, input color_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            error_count++;
        end
    endtask

    // galois form, taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one lfsr step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic vertex_t vtx(input int x, input int y, input int z);
        vertex_t v;
        v.x = coord_t'(x);
        v.y = coord_t'(y);
        v.z = coord_t'(z);
        return v;
    endfunction

    function automatic triangle_t tri3(input vertex_t v0, input vertex_t v1, input vertex_t v2);
        triangle_t t;
        t[0] = v0;
        t[1] = v1;
        t[2] = v2;
        return t;
    endfunction

    // cross product of the edges, then the facing and cosine rules
    function automatic color_t expected_color(input triangle_t t);
        longint ux, uy, uz, wx, wy, wz;
        longint nx, ny, nz, mag, q;
        ux = longint'(t[1].x) - longint'(t[0].x);
        uy = longint'(t[1].y) - longint'(t[0].y);
        uz = longint'(t[1].z) - longint'(t[0].z);
        wx = longint'(t[2].x) - longint'(t[0].x);
        wy = longint'(t[2].y) - longint'(t[0].y);
        wz = longint'(t[2].z) - longint'(t[0].z);
        nx = uy * wz - uz * wy;
        ny = uz * wx - ux * wz;
        nz = ux * wy - uy * wx;
        mag = nx * nx + ny * ny + nz * nz;
        if (nz < 0) begin
            return 8'd255;
        end
        if (mag == 0) begin
            return 8'd0;
        end
        q = (16 * nz * nz) / mag;
        if (q > 15) begin
            q = 15;
        end
        return SHADE_LEVELS[int'(q)];
    endfunction

    // strobe held until a cycle with ready high takes it
    task automatic send_triangle(input triangle_t t, input color_t exp);
        @(posedge clk);
        data_valid_in <= 1'b1;
        triangle      <= t;
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        expected_q.push_back(exp);
        @(posedge clk);
        data_valid_in <= 1'b0;
    endtask

    task automatic wait_results();
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        // room for a stray extra pulse to show up
        repeat (10) @(negedge clk);
    endtask

    task automatic test_reset_idle();
        test_name = "reset_idle";
        repeat (20) begin
            @(negedge clk);
            check_level(test_name, 1'b1, ready);
            check_level(test_name, 1'b0, valid_out);
        end
    endtask

    task automatic test_front_facing();
        test_name = "front_facing";
        // flat, counter-clockwise, cos^2 = 1
        send_triangle(tri3(vtx(0, 0, 0), vtx(10, 0, 0), vtx(0, 10, 0)), 8'd255);
        // normal (1, 0, 2), floor(64 / 5) = 12
        send_triangle(tri3(vtx(0, 0, 0), vtx(2, 0, -1), vtx(0, 1, 0)), 8'd210);
        wait_results();
    endtask

    task automatic test_back_facing();
        test_name = "back_facing";
        send_triangle(tri3(vtx(0, 0, 0), vtx(0, 10, 0), vtx(10, 0, 0)), 8'd255);
        send_triangle(tri3(vtx(0, 0, 0), vtx(0, 1, 0), vtx(2, 0, -1)), 8'd255);
        wait_results();
    endtask

    task automatic test_zero_normal();
        test_name = "zero_normal";
        // collinear
        send_triangle(tri3(vtx(0, 0, 0), vtx(1, 1, 1), vtx(2, 2, 2)), 8'd0);
        // edge-on in the xz plane
        send_triangle(tri3(vtx(0, 0, 0), vtx(5, 0, 0), vtx(0, 0, 5)), 8'd0);
        wait_results();
    endtask

    task automatic test_random_stream();
        triangle_t t;
        test_name = "random_stream";
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            for (int v = 0; v < 3; v++) begin
                t[v].x = coord_t'(take_bits(COORD_W));
                t[v].y = coord_t'(take_bits(COORD_W));
                t[v].z = coord_t'(take_bits(COORD_W));
            end
            send_triangle(t, expected_color(t));
        end
        wait_results();
    endtask

    // every result pulse is matched in acceptance order
    always @(negedge clk) begin
        if (!rst_in && valid_out) begin
            if (expected_q.size() == 0) begin
                $display("%s: valid_out pulsed with no triangle outstanding", test_name);
                error_count++;
            end else begin
                exp_color = expected_q.pop_front();
                check_color(test_name, exp_color, color_out);
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles in %s, %0d results never arrived",
                 cycle_cnt, test_name, expected_q.size());
        $display("errors: %0d", error_count + 1);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        data_valid_in = 1'b0;
        triangle      = '0;
        lfsr_state    = LFSR_SEED;
        error_count   = 0;
        test_name     = "reset";
        @(negedge clk);
        while (rst_in) begin
            @(negedge clk);
        end
        test_reset_idle();
        test_front_facing();
        test_back_facing();
        test_zero_normal();
        test_random_stream();
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
shade_pkg.sv
shade_ifs.sv
mult_arbiter.sv
normal_unit.sv
magnitude_unit.sv
shade_color.sv
pixel_shader.sv
tb_clock.sv
tb_pixel_shader.sv

/* Makefile */
TOP := tb_pixel_shader

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --top-module $(TOP) -Mdir obj_dir -f tb.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir
